/* aclink/frameShifter.sv */
`timescale 1ns/1ps
`include "ac97_defs.svh"

module frameShifter (
	input  logic                                clk_i,
	input  logic                                RESET,
	input  logic                                bitTick_i,
	input  logic [$clog2(`AC97_FRAME_BITS)-1:0] bitPos_i,
	input  logic                                frameStart_i,
	input  acLinkPkg::linkState_e               linkState_i,
	input  logic [`AC97_PCM_BITS-1:0]           pcm_i,
	input  logic                                acSdataIn_i,
	output logic                                acSync_o,
	output logic                                acSdataOut_o,
	output logic                                codecReady_o,
	slotBus.link                                bus_o
);

	localparam int POS_W     = $clog2(`AC97_FRAME_BITS);
	localparam int SLOT_W    = `AC97_SLOT_BITS;
	// Slots 0 to 4 carry data, the rest of the frame is zero
	localparam int OUT_BITS  = `AC97_TAG_BITS + 4 * SLOT_W;
	// Input tag, slot 1 and slot 2
	localparam int HEAD_BITS = `AC97_TAG_BITS + 2 * SLOT_W;
	localparam int ADDR_PAD  = SLOT_W - 1 - $bits(regMapPkg::codecAddr_t);
	localparam int DATA_PAD  = SLOT_W - 16;
	localparam int PCM_PAD   = SLOT_W - `AC97_PCM_BITS;

	logic [`AC97_TAG_BITS-1:0] tagOut;
	logic [`AC97_TAG_BITS-1:0] tagIn;
	logic [SLOT_W-1:0]         slot1Out;
	logic [SLOT_W-1:0]         slot2Out;
	logic [SLOT_W-1:0]         slot3Out;
	logic [SLOT_W-1:0]         slot4Out;
	logic [OUT_BITS-1:0]       frameOut;
	logic [OUT_BITS-1:0]       outShift;
	logic [HEAD_BITS-1:0]      headIn;
	logic                      running;
	logic                      scratchCmd;
	logic                      sendCmd;

	assign running    = linkState_i == acLinkPkg::LINK_RUN;
	// Scratch registers have no codec counterpart
	assign scratchCmd = regMapPkg::isScratch(regMapPkg::toRegIdx(bus_o.cmdAddr));
	assign sendCmd    = running && bus_o.cmdValid && !scratchCmd;
	// Any offered command is consumed, scratch ones are dropped here
	assign bus_o.cmdTake = frameStart_i && running && bus_o.cmdValid;

	// ----------------------------------------
	// Outgoing frame
	// ----------------------------------------
	always_comb begin
		tagOut   = '0;
		slot1Out = '0;
		slot2Out = '0;
		slot3Out = '0;
		slot4Out = '0;
		if (sendCmd) begin
			// Tag 0xE000, command address and data valid
			tagOut[acLinkPkg::TAG_VALID]    = 1'b1;
			tagOut[acLinkPkg::TAG_CMD_ADDR] = 1'b1;
			tagOut[acLinkPkg::TAG_CMD_DATA] = 1'b1;
			slot1Out = {bus_o.cmdKind == acLinkPkg::CMD_READ, bus_o.cmdAddr, {ADDR_PAD{1'b0}}};
			slot2Out = {bus_o.cmdData, {DATA_PAD{1'b0}}};
		end else if (running) begin
			// Tag 0x9800, same sample on left and right
			tagOut[acLinkPkg::TAG_VALID]     = 1'b1;
			tagOut[acLinkPkg::TAG_PCM_LEFT]  = 1'b1;
			tagOut[acLinkPkg::TAG_PCM_RIGHT] = 1'b1;
			slot3Out = {pcm_i, {PCM_PAD{1'b0}}};
			slot4Out = {pcm_i, {PCM_PAD{1'b0}}};
		end
	end

	assign frameOut = {tagOut, slot1Out, slot2Out, slot3Out, slot4Out};

	// MSB first, zeros fill after slot 4
	always_ff @(posedge clk_i) begin
		if (bitTick_i) begin
			outShift <= {(frameStart_i ? frameOut[OUT_BITS-2:0] : outShift[OUT_BITS-2:0]), 1'b0};
		end
	end

	always_ff @(posedge clk_i) begin
		if (RESET) begin
			acSync_o     <= 1'b0;
			acSdataOut_o <= 1'b0;
		end else if (bitTick_i) begin
			// SYNC covers the tag slot
			acSync_o     <= bitPos_i < POS_W'(`AC97_TAG_BITS);
			acSdataOut_o <= frameStart_i ? frameOut[OUT_BITS-1] : outShift[OUT_BITS-1];
		end
	end

	// ----------------------------------------
	// Incoming slots 0 to 2
	// ----------------------------------------
	assign tagIn = headIn[HEAD_BITS-1 -: `AC97_TAG_BITS];

	// Input bit n is sampled on the tick at position n+1
	always_ff @(posedge clk_i) begin
		if (RESET) begin
			headIn            <= '0;
			codecReady_o      <= 1'b0;
			bus_o.statusValid <= 1'b0;
		end else begin
			bus_o.statusValid <= 1'b0;
			if (frameStart_i) begin
				codecReady_o      <= tagIn[acLinkPkg::TAG_VALID];
				bus_o.statusValid <= tagIn[acLinkPkg::TAG_VALID] &&
					tagIn[acLinkPkg::TAG_CMD_ADDR] && tagIn[acLinkPkg::TAG_CMD_DATA];
			end else if (bitTick_i && bitPos_i <= POS_W'(HEAD_BITS)) begin
				headIn <= {headIn[HEAD_BITS-2:0], acSdataIn_i};
			end
		end
	end

	// Slot 1 bits 18:12 and slot 2 bits 19:4
	always_ff @(posedge clk_i) begin
		if (frameStart_i) begin
			bus_o.statusAddr <= headIn[2 * SLOT_W - 2 -: $bits(regMapPkg::codecAddr_t)];
			bus_o.statusData <= headIn[SLOT_W-1 -: 16];
		end
	end

endmodule

/* aclink/frameTimer.sv */
`timescale 1ns/1ps
`include "ac97_defs.svh"

module frameTimer (
	input  logic                                clk_i,
	input  logic                                RESET,
	output logic                                bitTick_o,
	output logic [$clog2(`AC97_FRAME_BITS)-1:0] bitPos_o,
	output logic                                frameStart_o,
	output logic                                acBitClk_o
);

	localparam int DIV_W = $clog2(`AC97_BIT_DIV);

	logic [DIV_W-1:0] prescale;

	// ----------------------------------------
	// Bit clock prescaler
	// ----------------------------------------

	// Tick on the last system clock of each bit period
	assign bitTick_o    = prescale == DIV_W'(`AC97_BIT_DIV - 1);
	// High for the first half of the bit
	assign acBitClk_o   = prescale < DIV_W'(`AC97_BIT_DIV / 2);
	// Bit 0 launches on this tick
	assign frameStart_o = bitTick_o && bitPos_o == '0;

	always_ff @(posedge clk_i) begin
		if (RESET) begin
			prescale <= '0;
			bitPos_o <= '0;
		end else if (bitTick_o) begin
			prescale <= '0;
			// Wraps at the frame length
			bitPos_o <= bitPos_o + 1'b1;
		end else begin
			prescale <= prescale + 1'b1;
		end
	end

endmodule

/* aclink/linkSequencer.sv */
`timescale 1ns/1ps
`include "ac97_defs.svh"

module linkSequencer (
	input  logic                  clk_i,
	input  logic                  RESET,
	input  logic                  frameStart_i,
	input  logic                  codecReady_i,
	output acLinkPkg::linkState_e linkState_o,
	output logic                  codecResetN_o
);

	localparam int CNT_W = $clog2(`AC97_RESET_FRAMES);

	acLinkPkg::linkState_e stateNext;
	logic [CNT_W-1:0]      frameCnt;
	logic                  resetDone;

	// Last frame start of the codec reset time
	assign resetDone = frameStart_i && frameCnt == CNT_W'(`AC97_RESET_FRAMES - 1);

	// ----------------------------------------
	// Next state
	// ----------------------------------------
	always_comb begin
		stateNext = linkState_o;
		case (linkState_o)
			acLinkPkg::LINK_RESET: if (resetDone) stateNext = acLinkPkg::LINK_WAIT;
			// Start streaming on a frame boundary
			acLinkPkg::LINK_WAIT: if (frameStart_i && codecReady_i) stateNext = acLinkPkg::LINK_RUN;
			// codec lost ready, stop sending
			acLinkPkg::LINK_RUN: if (!codecReady_i) stateNext = acLinkPkg::LINK_WAIT;
			default: stateNext = acLinkPkg::LINK_RESET;
		endcase
	end

	always_ff @(posedge clk_i) begin
		if (RESET) begin
			linkState_o   <= acLinkPkg::LINK_RESET;
			frameCnt      <= '0;
			codecResetN_o <= 1'b0;
		end else begin
			linkState_o <= stateNext;
			// Count frame starts while the codec is held in reset
			if (linkState_o == acLinkPkg::LINK_RESET && frameStart_i) begin
				frameCnt <= frameCnt + 1'b1;
			end
			if (resetDone && linkState_o == acLinkPkg::LINK_RESET) begin
				codecResetN_o <= 1'b1;
			end
		end
	end

endmodule

/* all.f */
+incdir+common
common/acLinkPkg.sv
common/regMapPkg.sv
common/slotBus.sv
shadow/shadowRegs.sv
aclink/frameTimer.sv
aclink/linkSequencer.sv
aclink/frameShifter.sv
logic/ac97Top.sv
bench/codecModel.sv
bench/tbAc97.sv

/* bench/codecModel.sv */
`timescale 1ns/1ps
`include "ac97_defs.svh"

// Behavioral AC'97 codec on the far side of the AC-link
module codecModel (
	input  logic        bitClk_i,
	input  logic        sync_i,
	input  logic        sdataOut_i,
	input  logic        resetN_i,
	input  logic [15:0] statusReply_i,
	output logic        sdataIn_o
);

	// Tag plus slots 1 to 4 of the outgoing frame
	logic [95:0] outBits;
	// Tag plus slots 1 and 2 of the incoming frame
	logic [55:0] inBits;
	logic        syncPrev;
	logic        replyPending;
	logic        ready;
	int          bitIdx;
	int          readyFrames;

	// Command log, read by the testbench
	int          logCount;
	logic [6:0]  logAddr [64];
	logic [15:0] logData [64];
	logic        logRead [64];

	// Last decoded frame
	int          frameCount;
	logic [15:0] lastTag;
	logic [17:0] lastLeft;
	logic [17:0] lastRight;

	initial begin
		outBits      = '0;
		inBits       = '0;
		syncPrev     = 1'b0;
		replyPending = 1'b0;
		ready        = 1'b0;
		bitIdx       = 1000;
		readyFrames  = 0;
		logCount     = 0;
		frameCount   = 0;
		lastTag      = '0;
		lastLeft     = '0;
		lastRight    = '0;
		sdataIn_o    = 1'b0;
	end

	// Codec samples and launches on the falling bit clock edge
	always @(negedge bitClk_i) begin
		if (sync_i && !syncPrev) begin
			bitIdx = 0;
			// Ready one frame after the reset release
			if (!resetN_i) begin
				readyFrames = 0;
			end else if (readyFrames < 2) begin
				readyFrames = readyFrames + 1;
			end
			ready  = readyFrames >= 2;
			inBits = '0;
			inBits[55] = ready;
			// Status reply goes out in the frame after the read command
			if (replyPending && ready) begin
				inBits[54]    = 1'b1;
				inBits[53]    = 1'b1;
				inBits[38:32] = 7'h26;
				inBits[19:4]  = statusReply_i;
			end
			replyPending = 1'b0;
		end else if (bitIdx < 1000) begin
			bitIdx = bitIdx + 1;
		end
		syncPrev = sync_i;
		if (bitIdx < 96) begin
			outBits[95 - bitIdx] = sdataOut_i;
		end
		// Decode once slot 4 is complete
		if (bitIdx == 95) begin
			lastTag    = outBits[95:80];
			lastLeft   = outBits[39:22];
			lastRight  = outBits[19:2];
			frameCount = frameCount + 1;
			if (outBits[95] && outBits[94] && logCount < 64) begin
				logAddr[logCount] = outBits[78:72];
				logData[logCount] = outBits[59:44];
				logRead[logCount] = outBits[79];
				if (outBits[79] && outBits[78:72] == 7'h26) begin
					replyPending = 1'b1;
				end
				logCount = logCount + 1;
			end
		end
		sdataIn_o <= (bitIdx < 56) ? inBits[55 - bitIdx] : 1'b0;
	end

endmodule

/* bench/tbAc97.sv */
`timescale 1ns/1ps
`include "ac97_defs.svh"

module tbAc97;

	logic                      clk;
	logic                      RESET;
	logic                      wbCyc;
	logic                      wbStb;
	logic                      wbWe;
	logic [6:0]                wbAdr;
	logic [15:0]               wbDatOut;
	logic [15:0]               wbDatIn;
	logic                      wbAck;
	logic [`AC97_PCM_BITS-1:0] pcm;
	logic                      acBitClk;
	logic                      acSync;
	logic                      acSdataOut;
	logic                      codecResetN;
	logic                      acSdataIn;
	logic [15:0]               replyValue;

	int errors;
	int timeouts;

	// Stimulus table: write flag, address, data, expected read value
	logic        tblWe     [32];
	logic [6:0]  tblAddr   [32];
	logic [15:0] tblData   [32];
	logic [15:0] tblExpect [32];
	int          tblCount;

	ac97Top dut_i (
		.clk_i         (clk),
		.RESET         (RESET),
		.wbCyc_i       (wbCyc),
		.wbStb_i       (wbStb),
		.wbWe_i        (wbWe),
		.wbAdr_i       (wbAdr),
		.wbDat_i       (wbDatOut),
		.wbDat_o       (wbDatIn),
		.wbAck_o       (wbAck),
		.pcm_i         (pcm),
		.acBitClk_o    (acBitClk),
		.acSync_o      (acSync),
		.acSdataOut_o  (acSdataOut),
		.codecResetN_o (codecResetN),
		.acSdataIn_i   (acSdataIn)
	);

	codecModel codec_i (
		.bitClk_i      (acBitClk),
		.sync_i        (acSync),
		.sdataOut_i    (acSdataOut),
		.resetN_i      (codecResetN),
		.statusReply_i (replyValue),
		.sdataIn_o     (acSdataIn)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	// ----------------------------------------
	// Checks and waits
	// ----------------------------------------
	task automatic checkValue(input string name, input logic [31:0] actual,
		input logic [31:0] expected);
		if (actual !== expected) begin
			$display("CHECK FAILED at %0t: %s got %h expected %h", $time, name, actual, expected);
			errors++;
		end
	endtask

	task automatic reportTimeout(input string what);
		$display("Timeout at %0t while waiting for %s", $time, what);
		timeouts++;
	endtask

	// One Wishbone classic cycle, ack sampled mid-cycle
	task automatic busCycle(input logic we, input logic [6:0] addr, input logic [15:0] wdata,
		output logic [15:0] rdata);
		int  cnt;
		logic seen;
		cnt   = 0;
		seen  = 1'b0;
		rdata = '0;
		@(posedge clk);
		wbCyc    <= 1'b1;
		wbStb    <= 1'b1;
		wbWe     <= we;
		wbAdr    <= addr;
		wbDatOut <= wdata;
		while (!seen && cnt < 20) begin
			@(negedge clk);
			cnt++;
			if (wbAck) begin
				seen  = 1'b1;
				rdata = wbDatIn;
			end
		end
		if (!seen) begin
			reportTimeout($sformatf("Wishbone ack at address %h", addr));
		end
		@(posedge clk);
		wbCyc <= 1'b0;
		wbStb <= 1'b0;
		wbWe  <= 1'b0;
	endtask

	task automatic readCheck(input logic [6:0] addr, input logic [15:0] expected);
		logic [15:0] rd;
		busCycle(1'b0, addr, 16'h0000, rd);
		checkValue($sformatf("wbDat_o[%h]", addr), 32'(rd), 32'(expected));
	endtask

	task automatic writeReg(input logic [6:0] addr, input logic [15:0] data);
		logic [15:0] rd;
		busCycle(1'b1, addr, data, rd);
	endtask

	// Bit clock over two bit periods, high for the first half of each
	task automatic checkBitClock;
		int   cnt;
		logic prev;
		logic seen;
		cnt  = 0;
		seen = 1'b0;
		prev = acBitClk;
		while (!seen && cnt < 20) begin
			@(negedge clk);
			cnt++;
			seen = acBitClk && !prev;
			prev = acBitClk;
		end
		if (!seen) begin
			reportTimeout("a rising bit clock");
		end else begin
			for (int k = 1; k < 2 * `AC97_BIT_DIV; k++) begin
				@(negedge clk);
				checkValue("acBitClk_o", 32'(acBitClk),
					32'((k % `AC97_BIT_DIV) < `AC97_BIT_DIV / 2));
			end
		end
	endtask

	// Frame starts seen as rising SYNC
	task automatic waitSyncRise(input int count);
		int   cnt;
		logic prev;
		logic seen;
		for (int k = 0; k < count; k++) begin
			cnt  = 0;
			seen = 1'b0;
			prev = acSync;
			while (!seen && cnt < 3000) begin
				@(negedge clk);
				cnt++;
				seen = acSync && !prev;
				prev = acSync;
			end
			if (!seen) begin
				reportTimeout("a frame start");
			end
		end
	endtask

	task automatic waitLog(input int target);
		int cnt;
		cnt = 0;
		while (codec_i.logCount < target && cnt < 10000) begin
			@(negedge clk);
			cnt++;
		end
		if (codec_i.logCount < target) begin
			reportTimeout("codec command log");
		end
	endtask

	task automatic waitFrames(input int target);
		int cnt;
		cnt = 0;
		while (codec_i.frameCount < target && cnt < 10000) begin
			@(negedge clk);
			cnt++;
		end
		if (codec_i.frameCount < target) begin
			reportTimeout("decoded frames");
		end
	endtask

	// Polls the pending register until all commands are taken
	task automatic waitIdle;
		logic [15:0] rd;
		int          polls;
		polls = 0;
		rd    = 16'hFFFF;
		while (rd != 16'h0000 && polls < 100) begin
			busCycle(1'b0, 7'h68, 16'h0000, rd);
			if (rd != 16'h0000) begin
				repeat (200) @(posedge clk);
			end
			polls++;
		end
		if (rd != 16'h0000) begin
			reportTimeout("pending commands to drain");
		end
	endtask

	task automatic addEntry(input logic we, input logic [6:0] addr, input logic [15:0] data,
		input logic [15:0] expected);
		tblWe[tblCount]     = we;
		tblAddr[tblCount]   = addr;
		tblData[tblCount]   = data;
		tblExpect[tblCount] = expected;
		tblCount++;
	endtask

	task automatic runTable(input int first, input int last);
		for (int i = first; i < last; i++) begin
			if (tblWe[i]) begin
				writeReg(tblAddr[i], tblData[i]);
			end else begin
				readCheck(tblAddr[i], tblExpect[i]);
			end
		end
	endtask

	// ----------------------------------------
	// Stimulus
	// ----------------------------------------
	initial begin
		int          cnt;
		int          base;
		int          fixedEnd;
		logic [6:0]  wrAddr [4];
		logic [6:0]  logOrder [4];
		logic [15:0] wrData [4];
		logic [15:0] value;
		logic [17:0] pcmValue;

		void'($urandom(32'h25ce));
		errors     = 0;
		timeouts   = 0;
		tblCount   = 0;
		RESET      = 1'b1;
		wbCyc      = 1'b0;
		wbStb      = 1'b0;
		wbWe       = 1'b0;
		wbAdr      = '0;
		wbDatOut   = '0;
		pcm        = '0;
		replyValue = '0;

		// Identity registers
		addEntry(1'b0, 7'h00, 16'h0000, `AC97_RESET_VALUE);
		addEntry(1'b0, 7'h22, 16'h0000, `AC97_EXT_ID);
		addEntry(1'b0, 7'h7C, 16'h0000, `AC97_VENDOR_ID1);
		addEntry(1'b0, 7'h7E, 16'h0000, `AC97_VENDOR_ID2);
		fixedEnd = tblCount;
		// Random write and readback of writable registers
		wrAddr = '{7'h02, 7'h04, 7'h18, 7'h2C};
		for (int i = 0; i < 4; i++) begin
			value = 16'($urandom);
			addEntry(1'b1, wrAddr[i], value, 16'h0000);
			addEntry(1'b0, wrAddr[i], 16'h0000, value);
		end

		repeat (4) @(posedge clk);
		RESET <= 1'b0;
		@(negedge clk);
		checkValue("codecResetN_o", 32'(codecResetN), 32'h0);
		checkValue("wbAck_o", 32'(wbAck), 32'h0);
		checkValue("acSync_o", 32'(acSync), 32'h0);
		checkValue("acSdataOut_o", 32'(acSdataOut), 32'h0);
		checkBitClock();

		// Codec reset release
		cnt = 0;
		while (!codecResetN && cnt < 10000) begin
			@(negedge clk);
			cnt++;
		end
		if (!codecResetN) begin
			reportTimeout("codec reset release");
		end
		runTable(0, fixedEnd);

		// Link streams once PCM frames appear
		cnt = 0;
		while (codec_i.lastTag != 16'h9800 && cnt < 20000) begin
			@(negedge clk);
			cnt++;
		end
		if (codec_i.lastTag != 16'h9800) begin
			reportTimeout("the link to start streaming");
		end

		runTable(fixedEnd, tblCount);
		waitIdle();
		waitSyncRise(2);

		// ----------------------------------------
		// Several writes inside one frame
		// ----------------------------------------
		base     = codec_i.logCount;
		wrAddr   = '{7'h02, 7'h2C, 7'h10, 7'h18};
		// Descending register index
		logOrder = '{7'h2C, 7'h18, 7'h10, 7'h02};
		waitSyncRise(1);
		for (int i = 0; i < 4; i++) begin
			wrData[i] = 16'($urandom);
			writeReg(wrAddr[i], wrData[i]);
		end
		readCheck(7'h68, 16'hFFFF);
		waitLog(base + 4);
		readCheck(7'h68, 16'h0000);
		for (int i = 0; i < 4; i++) begin
			checkValue("log address", 32'(codec_i.logAddr[base + i]), 32'(logOrder[i]));
			checkValue("log read flag", 32'(codec_i.logRead[base + i]), 32'h0);
			for (int j = 0; j < 4; j++) begin
				if (wrAddr[j] == logOrder[i]) begin
					checkValue("log data", 32'(codec_i.logData[base + i]), 32'(wrData[j]));
				end
			end
		end
		waitSyncRise(2);
		checkValue("log count", 32'(codec_i.logCount), 32'(base + 4));

		// ----------------------------------------
		// Read-only and scratch writes
		// ----------------------------------------
		base  = codec_i.logCount;
		value = 16'($urandom);
		writeReg(7'h7C, 16'($urandom));
		writeReg(7'h60, value);
		readCheck(7'h7C, `AC97_VENDOR_ID1);
		readCheck(7'h60, value);
		waitIdle();
		waitSyncRise(3);
		checkValue("log count", 32'(codec_i.logCount), 32'(base));

		// ----------------------------------------
		// Status read through 0x26
		// ----------------------------------------
		@(posedge clk);
		replyValue <= 16'($urandom);
		base = codec_i.logCount;
		writeReg(7'h26, 16'($urandom));
		waitLog(base + 1);
		checkValue("log address", 32'(codec_i.logAddr[base]), 32'h26);
		checkValue("log read flag", 32'(codec_i.logRead[base]), 32'h1);
		waitSyncRise(3);
		readCheck(7'h26, replyValue);

		// ----------------------------------------
		// PCM frames
		// ----------------------------------------
		pcmValue = 18'($urandom);
		@(posedge clk);
		pcm <= pcmValue;
		base = codec_i.frameCount;
		waitFrames(base + 3);
		checkValue("frame tag", 32'(codec_i.lastTag), 32'h9800);
		checkValue("pcm left", 32'(codec_i.lastLeft), 32'(pcmValue));
		checkValue("pcm right", 32'(codec_i.lastRight), 32'(pcmValue));

		$display("Summary: %0d check errors, %0d timeouts", errors, timeouts);
		if (errors == 0 && timeouts == 0) begin
			$display("TESTBENCH PASSED");
		end else begin
			$display("TESTBENCH FAILED");
		end
		$finish;
	end

endmodule

/* common/ac97_defs.svh */
`ifndef AC97_DEFS_SVH
`define AC97_DEFS_SVH

// ----------------------------------------
// AC-link frame format
// ----------------------------------------

// System clocks per AC-link bit
`define AC97_BIT_DIV       4
`define AC97_FRAME_BITS    256
`define AC97_TAG_BITS      16
`define AC97_SLOT_BITS     20
`define AC97_PCM_BITS      18
// Frame starts with the codec held in reset
`define AC97_RESET_FRAMES  4

// Fixed codec register contents
`define AC97_VENDOR_ID1    16'h4E53
`define AC97_VENDOR_ID2    16'h4350
`define AC97_RESET_VALUE   16'h0D50
`define AC97_EXT_ID        16'h0101

`endif

/* common/acLinkPkg.sv */
package acLinkPkg;

	// ----------------------------------------
	// Link state and command kinds
	// ----------------------------------------

	// Codec reset, wait for ready, then stream frames
	typedef enum logic [1:0] {
		LINK_RESET,
		LINK_WAIT,
		LINK_RUN
	} linkState_e;

	// Slot 1 bit 19, set for a register read
	typedef enum logic {
		CMD_WRITE,
		CMD_READ
	} cmdKind_e;

	// ----------------------------------------
	// Slot 0 tag bits
	// ----------------------------------------
	localparam int TAG_VALID     = 15;
	localparam int TAG_CMD_ADDR  = 14;
	localparam int TAG_CMD_DATA  = 13;
	// PCM left and right valid
	localparam int TAG_PCM_LEFT  = 12;
	localparam int TAG_PCM_RIGHT = 11;

endpackage

/* common/regMapPkg.sv */
package regMapPkg;

	typedef logic [4:0] regIdx_t;
	typedef logic [6:0] codecAddr_t;

	localparam codecAddr_t STATUS_ADDR   = 7'h26;
	localparam codecAddr_t PENDING_ADDR  = 7'h68;
	localparam regIdx_t    FIRST_SCRATCH = 5'd27;

	// Compressed index to codec address, 27 mixer registers then scratch space
	localparam codecAddr_t ADDR_MAP [32] = '{
		7'h00, 7'h02, 7'h04, 7'h06, 7'h0A, 7'h0C, 7'h0E, 7'h10,
		7'h12, 7'h14, 7'h16, 7'h18, 7'h1A, 7'h1C, 7'h20, 7'h22,
		7'h24, 7'h26, 7'h28, 7'h2A, 7'h2C, 7'h32, 7'h5A, 7'h74,
		7'h7A, 7'h7C, 7'h7E, 7'h60, 7'h62, 7'h64, 7'h66, 7'h68
	};

	function automatic codecAddr_t toCodecAddr(regIdx_t idx);
		return ADDR_MAP[idx];
	endfunction

	// Unmapped addresses land in the last scratch slot
	function automatic regIdx_t toRegIdx(codecAddr_t addr);
		regIdx_t idx;
		idx = 5'd31;
		for (int i = 0; i < 32; i++) begin
			if (ADDR_MAP[i] == addr) begin
				idx = regIdx_t'(i);
			end
		end
		return idx;
	endfunction

	function automatic logic isReadOnly(codecAddr_t addr);
		return addr inside {7'h00, 7'h22, 7'h5A, 7'h74, 7'h7C, 7'h7E};
	endfunction

	function automatic logic isScratch(regIdx_t idx);
		return idx >= FIRST_SCRATCH;
	endfunction

endpackage

/* common/slotBus.sv */
`timescale 1ns/1ps

// Pending codec command out of the shadow registers, status reply back in
interface slotBus;

	// Highest dirty register, registered on the regs side
	logic                  cmdValid;
	acLinkPkg::cmdKind_e   cmdKind;
	regMapPkg::codecAddr_t cmdAddr;
	logic [15:0]           cmdData;
	// Frame start pulse when the link consumes the command
	logic                  cmdTake;

	// Register read reply from input slots 1 and 2
	logic                  statusValid;
	regMapPkg::codecAddr_t statusAddr;
	logic [15:0]           statusData;

	modport regs (output cmdValid, cmdKind, cmdAddr, cmdData,
		input cmdTake, statusValid, statusAddr, statusData);
	modport link (input cmdValid, cmdKind, cmdAddr, cmdData,
		output cmdTake, statusValid, statusAddr, statusData);

endinterface

/* logic/ac97Top.sv */
`timescale 1ns/1ps
`include "ac97_defs.svh"

module ac97Top (
	input  logic                      clk_i,
	input  logic                      RESET,
	input  logic                      wbCyc_i,
	input  logic                      wbStb_i,
	input  logic                      wbWe_i,
	input  logic [6:0]                wbAdr_i,
	input  logic [15:0]               wbDat_i,
	output logic [15:0]               wbDat_o,
	output logic                      wbAck_o,
	input  logic [`AC97_PCM_BITS-1:0] pcm_i,
	output logic                      acBitClk_o,
	output logic                      acSync_o,
	output logic                      acSdataOut_o,
	output logic                      codecResetN_o,
	input  logic                      acSdataIn_i
);

	logic                                bitTick;
	logic [$clog2(`AC97_FRAME_BITS)-1:0] bitPos;
	logic                                frameStart;
	logic                                codecReady;
	acLinkPkg::linkState_e               linkState;

	// Command and status path between host side and link
	slotBus linkBus ();

	// ----------------------------------------
	// Host side
	// ----------------------------------------
	shadowRegs regs_i (
		.clk_i   (clk_i),
		.RESET   (RESET),
		.wbCyc_i (wbCyc_i),
		.wbStb_i (wbStb_i),
		.wbWe_i  (wbWe_i),
		.wbAdr_i (wbAdr_i),
		.wbDat_i (wbDat_i),
		.wbDat_o (wbDat_o),
		.wbAck_o (wbAck_o),
		.bus_i   (linkBus)
	);

	// ----------------------------------------
	// AC-link
	// ----------------------------------------
	frameTimer timer_i (
		.clk_i        (clk_i),
		.RESET        (RESET),
		.bitTick_o    (bitTick),
		.bitPos_o     (bitPos),
		.frameStart_o (frameStart),
		.acBitClk_o   (acBitClk_o)
	);

	linkSequencer seq_i (
		.clk_i         (clk_i),
		.RESET         (RESET),
		.frameStart_i  (frameStart),
		.codecReady_i  (codecReady),
		.linkState_o   (linkState),
		.codecResetN_o (codecResetN_o)
	);

	frameShifter shifter_i (
		.clk_i        (clk_i),
		.RESET        (RESET),
		.bitTick_i    (bitTick),
		.bitPos_i     (bitPos),
		.frameStart_i (frameStart),
		.linkState_i  (linkState),
		.pcm_i        (pcm_i),
		.acSdataIn_i  (acSdataIn_i),
		.acSync_o     (acSync_o),
		.acSdataOut_o (acSdataOut_o),
		.codecReady_o (codecReady),
		.bus_o        (linkBus)
	);

endmodule

/* run.sh */
#!/bin/sh
# Build and run the AC'97 controller testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f all.f --top-module tbAc97 -o simAc97
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

output=$(./obj_dir/simAc97)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if echo "$output" | grep -q "TESTBENCH PASSED"; then
	exit 0
fi
exit 1

/* shadow/shadowRegs.sv */
`timescale 1ns/1ps
`include "ac97_defs.svh"

module shadowRegs (
	input  logic                  clk_i,
	input  logic                  RESET,
	input  logic                  wbCyc_i,
	input  logic                  wbStb_i,
	input  logic                  wbWe_i,
	input  regMapPkg::codecAddr_t wbAdr_i,
	input  logic [15:0]           wbDat_i,
	output logic [15:0]           wbDat_o,
	output logic                  wbAck_o,
	slotBus.regs                  bus_i
);

	localparam int NUM_REGS = 2 ** $bits(regMapPkg::regIdx_t);

	logic [15:0]        regFile [NUM_REGS];
	logic [NUM_REGS-1:0] dirty;
	logic [NUM_REGS-1:0] dirtyNext;
	logic [15:0]        statusReg;
	logic [15:0]        readValue;
	logic               wbStart;
	logic               hostWr;
	regMapPkg::regIdx_t hostIdx;
	regMapPkg::regIdx_t scanIdx;
	regMapPkg::regIdx_t pendIdx;
	logic               scanValid;
	logic               scanRead;

	// ----------------------------------------
	// Wishbone slave
	// ----------------------------------------

	// First clock of a request, ack follows on the next
	assign wbStart = wbCyc_i && wbStb_i && !wbAck_o;
	assign hostIdx = regMapPkg::toRegIdx(wbAdr_i);
	// read-only registers are never written or marked dirty
	assign hostWr  = wbStart && wbWe_i && !regMapPkg::isReadOnly(wbAdr_i);

	// Identity registers are hard values, 0x5A and 0x74 stay at zero
	always_comb begin
		case (wbAdr_i)
			7'h00:                   readValue = `AC97_RESET_VALUE;
			7'h22:                   readValue = `AC97_EXT_ID;
			7'h7C:                   readValue = `AC97_VENDOR_ID1;
			7'h7E:                   readValue = `AC97_VENDOR_ID2;
			regMapPkg::STATUS_ADDR:  readValue = statusReg;
			regMapPkg::PENDING_ADDR: readValue = {16{|dirty}};
			default:                 readValue = regFile[hostIdx];
		endcase
	end

	always_ff @(posedge clk_i) begin
		if (RESET) begin
			wbAck_o <= 1'b0;
			wbDat_o <= '0;
		end else begin
			wbAck_o <= wbStart;
			wbDat_o <= wbStart ? readValue : '0;
		end
	end

	// ----------------------------------------
	// Register file and status capture
	// ----------------------------------------
	always_ff @(posedge clk_i) begin
		if (RESET) begin
			for (int i = 0; i < NUM_REGS; i++) begin
				regFile[i] <= '0;
			end
		end else if (hostWr) begin
			regFile[hostIdx] <= wbDat_i;
		end
	end

	// Only the reply for 0x26 is kept
	always_ff @(posedge clk_i) begin
		if (RESET) begin
			statusReg <= '0;
		end else if (bus_i.statusValid && bus_i.statusAddr == regMapPkg::STATUS_ADDR) begin
			statusReg <= bus_i.statusData;
		end
	end

	// ----------------------------------------
	// Dirty tracking
	// ----------------------------------------

	// A host write on the take clock keeps the bit set
	always_comb begin
		dirtyNext = dirty;
		if (bus_i.cmdTake) begin
			dirtyNext[pendIdx] = 1'b0;
		end
		if (hostWr) begin
			dirtyNext[hostIdx] = 1'b1;
		end
	end

	// Priority scan, highest index wins
	always_comb begin
		scanValid = 1'b0;
		scanIdx   = '0;
		for (int i = 0; i < NUM_REGS; i++) begin
			if (dirty[i]) begin
				scanValid = 1'b1;
				scanIdx   = regMapPkg::regIdx_t'(i);
			end
		end
	end

	// Status register goes out as a read
	assign scanRead = regMapPkg::toCodecAddr(scanIdx) == regMapPkg::STATUS_ADDR;

	always_ff @(posedge clk_i) begin
		if (RESET) begin
			dirty          <= '0;
			bus_i.cmdValid <= 1'b0;
		end else begin
			dirty          <= dirtyNext;
			bus_i.cmdValid <= scanValid;
		end
	end

	// Command payload follows the scan
	always_ff @(posedge clk_i) begin
		pendIdx       <= scanIdx;
		bus_i.cmdAddr <= regMapPkg::toCodecAddr(scanIdx);
		bus_i.cmdKind <= scanRead ? acLinkPkg::CMD_READ : acLinkPkg::CMD_WRITE;
		bus_i.cmdData <= scanRead ? '0 : regFile[scanIdx];
	end

endmodule
